//--- design/video_consts.svh
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// ----------------------------------------------------------------------
// display geometry shared by all four ST modes
// ----------------------------------------------------------------------

// visible pixels per line
`define VIDEO_H_ACT 640

// visible lines per frame
`define VIDEO_V_ACT 400

// ----------------------------------------------------------------------
// beam counter size
// ----------------------------------------------------------------------

// pal50 has the longest line at 1024 clocks
// so ten bits cover every position on both axes
`define VIDEO_CNT_W 10

`endif

//--- design/video_pkg.sv
`default_nettype none

`include "video_consts.svh"

package video_pkg;

	// ------------------------------------------------------------------
	// coordinates
	// ------------------------------------------------------------------

	// one beam position on either axis
	typedef logic [`VIDEO_CNT_W-1:0] pix_coord_t;

	// ------------------------------------------------------------------
	// timing words
	// ------------------------------------------------------------------

	// edges of one axis, each is the last position of its region
	// order follows the scan: active, border, porch, sync, porch, border
	typedef struct packed {
		// level of the sync pulse while active
		logic       sync_pol;
		// last active position
		pix_coord_t act_end;
		// border right after the active area
		pix_coord_t border_a_end;
		pix_coord_t porch_f_end;
		pix_coord_t sync_end;
		pix_coord_t porch_b_end;
		// border before active, also the wrap point of the axis
		pix_coord_t total_end;
	} axis_timing_t;

	// horizontal half sits in the upper bits
	typedef struct packed {
		axis_timing_t h;
		axis_timing_t v;
	} mode_timing_t;

	// ------------------------------------------------------------------
	// screen modes
	// ------------------------------------------------------------------

	typedef enum logic [1:0] {
		mode_mono  = 2'd0,
		mode_pal56 = 2'd1,
		mode_pal50 = 2'd2,
		mode_ntsc  = 2'd3
	} video_mode_e;

endpackage

`default_nettype wire

//--- design/beam_if.sv
`timescale 1ns/1ns
`default_nettype none

// beam position and line/frame strobes
// counter drives it, sync decoder reads it
interface beam_if import video_pkg::*; ();

	// current horizontal pixel
	pix_coord_t h_pos;
	// current line
	pix_coord_t v_pos;
	// high for the one cycle at h_pos 0
	logic       line_start;
	// high for the one cycle at 0,0
	logic       frame_start;

	// counter side
	modport source (
		output h_pos,
		output v_pos,
		output line_start,
		output frame_start
	);

	// decoder side
	modport sink (
		input h_pos,
		input v_pos,
		input line_start,
		input frame_start
	);

endinterface

`default_nettype wire

//--- design/video_mode_table.sv
`timescale 1ns/1ns
`default_nettype none

`include "video_consts.svh"

module video_mode_table import video_pkg::*; (
	input  wire          clk,
	input  wire          reset,
	// monochrome monitor attached
	input  wire          mono,
	// pal instead of ntsc for colour
	input  wire          pal,
	// 56 hz variant of pal
	input  wire          pal56,
	output mode_timing_t timing
);

	// ------------------------------------------------------------------
	// edge accumulation
	// ------------------------------------------------------------------

	// widths are summed onto the active size in scan order
	// border after active, front porch, sync, back porch, border before
	function automatic axis_timing_t axis_edges(
		input int   act,
		input int   bd_a,
		input int   fp,
		input int   s,
		input int   bp,
		input int   bd_b,
		input logic pol
	);
		int           pos;
		axis_timing_t t;
		t.sync_pol     = pol;
		pos            = act;
		t.act_end      = pix_coord_t'(pos - 1);
		pos            = pos + bd_a;
		t.border_a_end = pix_coord_t'(pos - 1);
		pos            = pos + fp;
		t.porch_f_end  = pix_coord_t'(pos - 1);
		pos            = pos + s;
		t.sync_end     = pix_coord_t'(pos - 1);
		pos            = pos + bp;
		t.porch_b_end  = pix_coord_t'(pos - 1);
		pos            = pos + bd_b;
		t.total_end    = pix_coord_t'(pos - 1);
		return t;
	endfunction

	// ------------------------------------------------------------------
	// the four ST modes
	// ------------------------------------------------------------------

	// args: active, border after, front porch, sync, back porch, border before, pol
	// vertical border after active is the bottom one, before active the top one

	// 71 hz high res, 896x501, no border at all
	localparam mode_timing_t MONO_SET = '{
		h: axis_edges(`VIDEO_H_ACT,  0, 108,  40, 108,  0, 1'b0),
		v: axis_edges(`VIDEO_V_ACT,  0,  48,   5,  48,  0, 1'b0)
	};

	// 56 hz pal replacement, 928x612
	localparam mode_timing_t PAL56_SET = '{
		h: axis_edges(`VIDEO_H_ACT, 40,  44, 120,  44, 40, 1'b1),
		v: axis_edges(`VIDEO_V_ACT, 80,  24,   4,  24, 80, 1'b1)
	};

	// 50 hz pal, 1024x626
	localparam mode_timing_t PAL50_SET = '{
		h: axis_edges(`VIDEO_H_ACT, 80,  80,  64,  80, 80, 1'b1),
		v: axis_edges(`VIDEO_V_ACT, 80,  30,   6,  30, 80, 1'b1)
	};

	// 60 hz ntsc, 1016x526, vsync active low
	localparam mode_timing_t NTSC_SET = '{
		h: axis_edges(`VIDEO_H_ACT, 80,  76,  64,  76, 80, 1'b1),
		v: axis_edges(`VIDEO_V_ACT, 40,  20,   6,  20, 40, 1'b0)
	};

	// ------------------------------------------------------------------
	// selection
	// ------------------------------------------------------------------

	video_mode_e  sel_mode;
	mode_timing_t sel_timing;

	// mono overrides colour, pal56 only counts with pal
	always_comb begin
		if (mono)
			sel_mode = mode_mono;
		else if (pal)
			sel_mode = pal56 ? mode_pal56 : mode_pal50;
		else
			sel_mode = mode_ntsc;
	end

	always_comb begin
		case (sel_mode)
			mode_mono:  sel_timing = MONO_SET;
			mode_pal56: sel_timing = PAL56_SET;
			mode_pal50: sel_timing = PAL50_SET;
			default:    sel_timing = NTSC_SET;
		endcase
	end

	// loads every cycle, so the selection is already in place when reset lifts
	always_ff @(posedge clk) begin
		timing <= sel_timing;
	end

	// porch and sync regions are never empty
	// a border of zero width lets its edge sit on the one before it (mono)
	function automatic logic axis_ordered(input axis_timing_t t);
		return (t.border_a_end >= t.act_end) &&
			(t.porch_f_end > t.border_a_end) &&
			(t.sync_end > t.porch_f_end) &&
			(t.porch_b_end > t.sync_end) &&
			(t.total_end >= t.porch_b_end);
	endfunction

	a_edges_ordered: assert property (@(posedge clk) disable iff (reset)
		axis_ordered(timing.h) && axis_ordered(timing.v));

endmodule

`default_nettype wire

//--- design/beam_counter.sv
`timescale 1ns/1ns
`default_nettype none

module beam_counter import video_pkg::*; (
	input  wire          clk,
	input  wire          reset,
	// registered timing word from the mode table
	input  wire          mode_timing_t timing,
	beam_if.source       beam
);

	// ------------------------------------------------------------------
	// mode change detect
	// ------------------------------------------------------------------

	// copy of the timing seen on the previous cycle
	mode_timing_t timing_q;
	logic         mode_change;

	always_ff @(posedge clk) begin
		timing_q <= timing;
	end

	// any difference means a new mode was selected
	assign mode_change = (timing != timing_q);

	// ------------------------------------------------------------------
	// position counters
	// ------------------------------------------------------------------

	pix_coord_t h_cnt;
	pix_coord_t v_cnt;
	logic       h_wrap;
	logic       v_wrap;

	// last pixel of the line, last line of the frame
	assign h_wrap = (h_cnt == timing.h.total_end);
	assign v_wrap = (v_cnt == timing.v.total_end);

	always_ff @(posedge clk) begin
		if (reset || mode_change) begin
			// start the new frame at the top left corner
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_wrap) begin
			h_cnt <= '0;
			// vertical only moves at the end of a line
			if (v_wrap)
				v_cnt <= '0;
			else
				v_cnt <= v_cnt + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// ------------------------------------------------------------------
	// beam outputs
	// ------------------------------------------------------------------

	assign beam.h_pos       = h_cnt;
	assign beam.v_pos       = v_cnt;
	assign beam.line_start  = (h_cnt == '0);
	assign beam.frame_start = (h_cnt == '0) && (v_cnt == '0);

	// old positions may lie beyond the new totals until the restart lands
	a_pos_in_range: assert property (@(posedge clk) disable iff (reset)
		!mode_change |->
		(h_cnt <= timing.h.total_end) && (v_cnt <= timing.v.total_end));

	// a frame always opens on a line boundary
	a_frame_on_line: assert property (@(posedge clk) disable iff (reset)
		beam.frame_start |-> beam.line_start);

endmodule

`default_nettype wire

//--- design/sync_decode.sv
`timescale 1ns/1ns
`default_nettype none

module sync_decode import video_pkg::*; (
	input  wire          clk,
	input  wire          reset,
	input  wire          mode_timing_t timing,
	beam_if.sink         beam,
	output logic         hsync,
	output logic         vsync,
	// display enable, inside the 640x400 area
	output logic         de,
	// visible but outside the display area
	output logic         border,
	output logic         frame_start,
	// position that goes with de
	output pix_coord_t   x,
	output pix_coord_t   y
);

	// ------------------------------------------------------------------
	// region tests for one axis
	// ------------------------------------------------------------------

	// sync region starts right after the front porch
	function automatic logic in_sync(input axis_timing_t t, input pix_coord_t p);
		return (p > t.porch_f_end) && (p <= t.sync_end);
	endfunction

	// visible is active plus both borders
	function automatic logic in_visible(input axis_timing_t t, input pix_coord_t p);
		return (p <= t.border_a_end) || (p > t.porch_b_end);
	endfunction

	// ------------------------------------------------------------------
	// next values
	// ------------------------------------------------------------------

	logic hsync_d;
	logic vsync_d;
	logic de_d;
	logic h_vis;
	logic v_vis;
	logic border_d;

	// polarity applied here, pol is the level during the pulse
	assign hsync_d = in_sync(timing.h, beam.h_pos) ? timing.h.sync_pol : ~timing.h.sync_pol;
	assign vsync_d = in_sync(timing.v, beam.v_pos) ? timing.v.sync_pol : ~timing.v.sync_pol;

	assign de_d = (beam.h_pos <= timing.h.act_end) && (beam.v_pos <= timing.v.act_end);

	assign h_vis    = in_visible(timing.h, beam.h_pos);
	assign v_vis    = in_visible(timing.v, beam.v_pos);
	assign border_d = h_vis && v_vis && !de_d;

	// ------------------------------------------------------------------
	// output registers
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			// syncs idle at the inactive level of the current mode
			hsync       <= ~timing.h.sync_pol;
			vsync       <= ~timing.v.sync_pol;
			de          <= 1'b0;
			border      <= 1'b0;
			frame_start <= 1'b0;
		end else begin
			hsync       <= hsync_d;
			vsync       <= vsync_d;
			de          <= de_d;
			border      <= border_d;
			frame_start <= beam.frame_start;
		end
	end

	// same stage as de, so x/y line up with the pixel
	always_ff @(posedge clk) begin
		x <= beam.h_pos;
		y <= beam.v_pos;
	end

	a_de_excl_border: assert property (@(posedge clk) disable iff (reset)
		!(de && border));

endmodule

`default_nettype wire

//--- design/video_timing_top.sv
`timescale 1ns/1ns
`default_nettype none

module video_timing_top import video_pkg::*; (
	input  wire        clk,
	input  wire        reset,
	// mode selects, plain levels
	input  wire        mono,
	input  wire        pal,
	input  wire        pal56,
	output logic       hsync,
	output logic       vsync,
	output logic       de,
	output logic       border,
	output logic       frame_start,
	output pix_coord_t x,
	output pix_coord_t y
);

	// ------------------------------------------------------------------
	// stage wiring
	// ------------------------------------------------------------------

	// registered timing word, shared by counter and decoder
	mode_timing_t timing;

	// beam position from counter to decoder
	beam_if beam ();

	// mode selects to timing word, one cycle
	video_mode_table u_mode_table (
		.clk    (clk),
		.reset  (reset),
		.mono   (mono),
		.pal    (pal),
		.pal56  (pal56),
		.timing (timing)
	);

	// restarts the frame the cycle after timing changes
	beam_counter u_beam_counter (
		.clk    (clk),
		.reset  (reset),
		.timing (timing),
		.beam   (beam.source)
	);

	// outputs trail the beam position by one cycle
	sync_decode u_sync_decode (
		.clk         (clk),
		.reset       (reset),
		.timing      (timing),
		.beam        (beam.sink),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.border      (border),
		.frame_start (frame_start),
		.x           (x),
		.y           (y)
	);

endmodule

`default_nettype wire

//--- testbench/video_timing_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "video_consts.svh"

module video_timing_tb import video_pkg::*; ();

	// pal50 frame is 1024x626 clocks, the longest of the four
	localparam int FRAME_LIMIT  = 700000;
	localparam int SWITCH_LIMIT = 16;

	logic       clk = 1'b0;
	logic       reset;
	logic       mono;
	logic       pal;
	logic       pal56;
	logic       hsync;
	logic       vsync;
	logic       de;
	logic       border;
	logic       frame_start;
	pix_coord_t x;
	pix_coord_t y;

	// per mode widths, border is equal on both sides of the active area
	int          h_bd [4];
	int          h_fp [4];
	int          h_sw [4];
	int          h_bp [4];
	int          v_bd [4];
	int          v_fp [4];
	int          v_sw [4];
	int          v_bp [4];
	logic        h_pol [4];
	logic        v_pol [4];
	video_mode_e order [4];

	video_timing_top DUT (
		.clk         (clk),
		.reset       (reset),
		.mono        (mono),
		.pal         (pal),
		.pal56       (pal56),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.border      (border),
		.frame_start (frame_start),
		.x           (x),
		.y           (y)
	);

	always #10 clk = ~clk;

	// ------------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------------

	task automatic check_coord(input string name, input pix_coord_t exp, input pix_coord_t act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
			$display("test failed");
			$fatal(1, "coordinate mismatch");
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
			$display("test failed");
			$fatal(1, "count mismatch");
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
			$display("test failed");
			$fatal(1, "level mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: %s did not arrive within the cycle limit", what);
		$display("test failed");
		$fatal(1, "wait limit reached");
	endtask

	// ------------------------------------------------------------------
	// mode data and helpers
	// ------------------------------------------------------------------

	// args: border, front porch, sync, back porch, pol for h then v
	task automatic set_row(input video_mode_e m, input int hb, input int hf, input int hs,
		input int hp, input logic hpol, input int vb, input int vf, input int vs,
		input int vp, input logic vpol);
		h_bd[m] = hb;
		h_fp[m] = hf;
		h_sw[m] = hs;
		h_bp[m] = hp;
		h_pol[m] = hpol;
		v_bd[m] = vb;
		v_fp[m] = vf;
		v_sw[m] = vs;
		v_bp[m] = vp;
		v_pol[m] = vpol;
	endtask

	function automatic int h_total(input video_mode_e m);
		return `VIDEO_H_ACT + 2 * h_bd[m] + h_fp[m] + h_sw[m] + h_bp[m];
	endfunction

	function automatic int v_total(input video_mode_e m);
		return `VIDEO_V_ACT + 2 * v_bd[m] + v_fp[m] + v_sw[m] + v_bp[m];
	endfunction

	// mono wins, pal56 only picks between the two pal modes
	task automatic drive_select(input video_mode_e m);
		mono  <= (m == mode_mono);
		pal   <= (m == mode_pal56) || (m == mode_pal50);
		pal56 <= (m == mode_pal56);
	endtask

	// select change to frame_start is three registered stages
	task automatic switch_mode(input video_mode_e m);
		int n;
		@(posedge clk);
		drive_select(m);
		@(negedge clk);
		n = 0;
		while (frame_start !== 1'b1) begin
			if (n >= SWITCH_LIMIT)
				report_timeout({m.name(), " frame_start after mode switch"});
			@(negedge clk);
			n++;
		end
		check_count({m.name(), " restart delay"}, 3, n);
		check_coord({m.name(), " restart x"}, pix_coord_t'(0), x);
		check_coord({m.name(), " restart y"}, pix_coord_t'(0), y);
	endtask

	// ------------------------------------------------------------------
	// one frame, sampled at the falling edge
	// ------------------------------------------------------------------

	task automatic scan_frame(input video_mode_e m);
		string tag;
		int    n;
		int    htot;
		int    de_run;
		int    de_lines;
		int    hs_run;
		int    hs_pulses;
		int    vs_cycles;
		int    bd_line;
		int    bd_total;
		logic  de_prev;
		logic  line_de;
		logic  done;
		tag = m.name();
		htot = h_total(m);
		n = 0;
		de_run = 0;
		de_lines = 0;
		hs_run = 0;
		hs_pulses = 0;
		vs_cycles = 0;
		bd_line = 0;
		bd_total = 0;
		de_prev = 1'b0;
		line_de = 1'b0;
		done = 1'b0;
		while (!done) begin
			check_level({tag, " de with border"}, 1'b0, de & border);
			if (de && !de_prev) begin
				check_coord({tag, " de start x"}, pix_coord_t'(0), x);
				de_run = 0;
			end
			if (de)
				de_run++;
			if (!de && de_prev) begin
				check_count({tag, " de run"}, `VIDEO_H_ACT, de_run);
				de_lines++;
			end
			de_prev = de;
			// hsync pulse opens right after the front porch
			if (hsync == h_pol[m]) begin
				if (hs_run == 0)
					check_coord({tag, " hsync start x"},
						pix_coord_t'(`VIDEO_H_ACT + h_bd[m] + h_fp[m]), x);
				hs_run++;
			end else if (hs_run != 0) begin
				check_count({tag, " hsync width"}, h_sw[m], hs_run);
				hs_run = 0;
				hs_pulses++;
			end
			if (vsync == v_pol[m]) begin
				if (vs_cycles == 0)
					check_coord({tag, " vsync start y"},
						pix_coord_t'(`VIDEO_V_ACT + v_bd[m] + v_fp[m]), y);
				vs_cycles++;
			end
			if (border) begin
				bd_line++;
				bd_total++;
			end
			if (de)
				line_de = 1'b1;
			if (x == pix_coord_t'(htot - 1)) begin
				if (line_de)
					check_count({tag, " border per display line"}, 2 * h_bd[m], bd_line);
				bd_line = 0;
				line_de = 1'b0;
			end
			@(negedge clk);
			n++;
			if (frame_start === 1'b1)
				done = 1'b1;
			else if (n >= FRAME_LIMIT)
				report_timeout({tag, " next frame_start"});
		end
		check_count({tag, " frame cycles"}, htot * v_total(m), n);
		check_count({tag, " lines with de"}, `VIDEO_V_ACT, de_lines);
		check_count({tag, " hsync pulses"}, v_total(m), hs_pulses);
		check_count({tag, " vsync lines"}, v_sw[m], vs_cycles / htot);
		check_count({tag, " vsync partial line"}, 0, vs_cycles % htot);
		// visible rectangle minus display area, zero in mono
		check_count({tag, " border cycles"},
			(`VIDEO_H_ACT + 2 * h_bd[m]) * (`VIDEO_V_ACT + 2 * v_bd[m]) -
			`VIDEO_H_ACT * `VIDEO_V_ACT, bd_total);
	endtask

	// pal56 has no effect while pal is low, beam keeps running
	task automatic pal56_ignored_in_ntsc();
		pix_coord_t x0;
		x0 = x;
		@(posedge clk);
		pal56 <= ~pal56;
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			check_level("ntsc pal56 toggle frame_start", 1'b0, frame_start);
		end
		check_coord("ntsc pal56 toggle x",
			pix_coord_t'((int'(x0) + 8) % h_total(mode_ntsc)), x);
	endtask

	// ------------------------------------------------------------------
	// run
	// ------------------------------------------------------------------

	initial begin
		int          j;
		video_mode_e tmp;
		reset <= 1'b1;
		void'($urandom(32'hc761));
		set_row(mode_mono, 0, 108, 40, 108, 1'b0, 0, 48, 5, 48, 1'b0);
		set_row(mode_pal56, 40, 44, 120, 44, 1'b1, 80, 24, 4, 24, 1'b1);
		set_row(mode_pal50, 80, 80, 64, 80, 1'b1, 80, 30, 6, 30, 1'b1);
		set_row(mode_ntsc, 80, 76, 64, 76, 1'b1, 40, 20, 6, 20, 1'b0);
		order[0] = mode_mono;
		order[1] = mode_pal56;
		order[2] = mode_pal50;
		order[3] = mode_ntsc;
		for (int i = 3; i > 0; i--) begin
			j = int'($urandom % (i + 1));
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		// reset in the last mode so the first switch is a real change
		drive_select(order[3]);
		repeat (3) @(posedge clk);
		@(negedge clk);
		check_level("reset de", 1'b0, de);
		check_level("reset border", 1'b0, border);
		check_level("reset frame_start", 1'b0, frame_start);
		check_level("reset hsync", ~h_pol[order[3]], hsync);
		check_level("reset vsync", ~v_pol[order[3]], vsync);
		check_coord("reset x", pix_coord_t'(0), x);
		@(posedge clk);
		reset <= 1'b0;
		repeat (10) @(negedge clk);
		for (int i = 0; i < 4; i++) begin
			switch_mode(order[i]);
			scan_frame(order[i]);
			if (order[i] == mode_ntsc)
				pal56_ignored_in_ntsc();
		end
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+design
design/video_pkg.sv
design/beam_if.sv
design/video_mode_table.sv
design/beam_counter.sv
design/sync_decode.sv
design/video_timing_top.sv
testbench/video_timing_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := video_timing_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

SOURCES := $(shell grep -v '^+' $(FILELIST)) design/video_consts.svh

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)
